// ==== hw/flash_prog_pkg.sv ====
package flash_prog_pkg;

  ////////////////////
  // bus side
  ////////////////////

  // data bits per bus beat
  localparam int BusWidth      = 32;
  // odd parity, one bit per byte, sits above the data
  // a byte is good when its 8 bits plus the parity bit hold an odd number of ones
  localparam int BusParW       = 4;
  localparam int ByteWidth     = BusWidth / BusParW;
  localparam int BusFullWidth  = BusWidth + BusParW;
  // beats per flash word and the beat index
  localparam int WidthMultiple = 2;
  localparam int WordSelW      = 1;
  localparam int MaxBeatIdx    = WidthMultiple - 1;

  ////////////////////
  // flash side
  ////////////////////

  localparam int DataWidth     = BusWidth * WidthMultiple;
  localparam int CodeWidth     = 8;
  // programmed word is {reliability code, integrity code, data}
  localparam int FullDataWidth = DataWidth + 2 * CodeWidth;
  // the reliability code covers the integrity code stacked above the data
  localparam int CodeInWidth   = DataWidth + CodeWidth;
  localparam int AddrWidth     = 16;

  // scrambler round counts and rotation amounts
  localparam int MaskRounds    = 4;
  localparam int CipherRounds  = 4;
  localparam int MaskRot       = 7;
  localparam int CipherRot     = 13;
  localparam int RoundCntW     = 3;

  // code rule, used for both 8-bit codes
  //   bit j, j = 0..5 : xor of all input bits whose index has bit j set
  //   bit 6           : xor of all input bits
  //   bit 7           : xor of the even-indexed input bits
  // for the 72-bit reliability input the index for bits 0..5 is taken modulo 64

  typedef logic [BusFullWidth-1:0]  bus_word_t;
  typedef logic [WordSelW-1:0]      beat_sel_t;
  typedef logic [DataWidth-1:0]     flash_data_t;
  typedef logic [CodeWidth-1:0]     code_t;
  typedef logic [FullDataWidth-1:0] flash_word_t;
  typedef logic [AddrWidth-1:0]     flash_addr_t;
  typedef logic [DataWidth-1:0]     flash_key_t;

endpackage

// ==== hw/flash_prog_ecc_enc.sv ====
`timescale 1ns/100ps

module flash_prog_ecc_enc import flash_prog_pkg::*; (
  // current word register, plain or scrambled
  input  flash_data_t data_i,
  // integrity code captured from the plain word
  input  code_t       intg_i,
  output code_t       intg_code_o,
  output code_t       rel_code_o
);

  logic [CodeInWidth-1:0] intg_in;
  logic [CodeInWidth-1:0] rel_in;

  // one generator for both codes
  // positions 0..5 use the bit index modulo the data width
  function automatic code_t calc_code(logic [CodeInWidth-1:0] v);
    code_t       c;
    int unsigned k;
    c = '0;
    for (int i = 0; i < CodeInWidth; i++) begin
      k = i % DataWidth;
      // index-weighted parity bits
      for (int j = 0; j < 6; j++) begin
        if (k[j]) begin
          c[j] = c[j] ^ v[i];
        end
      end
      // overall parity
      c[6] = c[6] ^ v[i];
      // even-position parity
      if ((i % 2) == 0) begin
        c[7] = c[7] ^ v[i];
      end
    end
    return c;
  endfunction

  ////////////////////
  // code inputs
  ////////////////////

  // zero top byte leaves the 64-bit code untouched
  assign intg_in = {{CodeWidth{1'b0}}, data_i};

  // integrity code sits above the final data
  assign rel_in = {intg_i, data_i};

  // the packer samples this only while the word is still plain
  assign intg_code_o = calc_code(intg_in);

  // covers whatever goes to the flash, scrambled or not
  assign rel_code_o = calc_code(rel_in);

endmodule

// ==== hw/flash_prog_scramble.sv ====
`timescale 1ns/100ps

module flash_prog_scramble import flash_prog_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  flash_key_t  key_i,
  input  flash_addr_t addr_i,
  // address mask
  input  logic        mask_req_i,
  output logic        mask_ack_o,
  output flash_data_t mask_o,
  // keyed cipher
  input  logic        cipher_req_i,
  input  flash_data_t cipher_data_i,
  output logic        cipher_ack_o,
  output flash_data_t cipher_o
);

  logic                 mask_busy_q;
  logic [RoundCntW-1:0] mask_cnt_q;
  flash_data_t          mask_q;
  logic                 cipher_busy_q;
  logic [RoundCntW-1:0] cipher_cnt_q;
  flash_data_t          cipher_q;

  function automatic flash_data_t rotl(flash_data_t x, int unsigned r);
    return (x << r) | (x >> (DataWidth - r));
  endfunction

  ////////////////////
  // mask unit
  ////////////////////

  // load on req, one round per cycle, ack after the last round
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_busy_q <= 1'b0;
      mask_cnt_q  <= '0;
      mask_ack_o  <= 1'b0;
    end else begin
      mask_ack_o <= 1'b0;
      if (mask_busy_q) begin
        mask_cnt_q <= mask_cnt_q + 1'b1;
        if (mask_cnt_q == RoundCntW'(MaskRounds - 1)) begin
          mask_busy_q <= 1'b0;
          mask_ack_o  <= 1'b1;
        end
      end else if (mask_req_i && !mask_ack_o) begin
        mask_busy_q <= 1'b1;
        mask_cnt_q  <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mask_busy_q) begin
      mask_q <= rotl(mask_q, MaskRot) ^ key_i;
    end else if (mask_req_i && !mask_ack_o) begin
      // address is zero-extended into the key
      mask_q <= key_i ^ flash_data_t'(addr_i);
    end
  end

  assign mask_o = mask_q;

  ////////////////////
  // cipher unit
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cipher_busy_q <= 1'b0;
      cipher_cnt_q  <= '0;
      cipher_ack_o  <= 1'b0;
    end else begin
      cipher_ack_o <= 1'b0;
      if (cipher_busy_q) begin
        cipher_cnt_q <= cipher_cnt_q + 1'b1;
        if (cipher_cnt_q == RoundCntW'(CipherRounds - 1)) begin
          cipher_busy_q <= 1'b0;
          cipher_ack_o  <= 1'b1;
        end
      end else if (cipher_req_i && !cipher_ack_o) begin
        cipher_busy_q <= 1'b1;
        cipher_cnt_q  <= '0;
      end
    end
  end

  // add-rotate round, the add wraps at 64 bits
  always_ff @(posedge clk_i) begin
    if (cipher_busy_q) begin
      cipher_q <= rotl(cipher_q + key_i, CipherRot);
    end else if (cipher_req_i && !cipher_ack_o) begin
      cipher_q <= cipher_data_i;
    end
  end

  assign cipher_o = cipher_q;

  // the packer holds each req until its ack
  mask_ack_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mask_ack_o |-> mask_req_i);
  cipher_ack_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cipher_ack_o |-> cipher_req_i);

endmodule

// ==== hw/flash_prog_pack.sv ====
`timescale 1ns/100ps

module flash_prog_pack import flash_prog_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        disable_i,
  // controller beat
  input  logic        prog_req_i,
  input  bus_word_t   data_i,
  input  beat_sel_t   sel_i,
  input  logic        last_i,
  input  logic        scramble_en_i,
  input  logic        ecc_en_i,
  // flash macro handshake
  input  logic        flash_ack_i,
  input  logic        flash_done_i,
  // scrambler results
  input  logic        mask_ack_i,
  input  flash_data_t mask_i,
  input  logic        cipher_ack_i,
  input  flash_data_t cipher_i,
  // encoder results
  input  code_t       intg_code_i,
  input  code_t       rel_code_i,
  output logic        prog_ack_o,
  output logic        flash_req_o,
  output logic        flash_last_o,
  output flash_word_t flash_data_o,
  output logic        mask_req_o,
  output logic        cipher_req_o,
  output flash_data_t cipher_data_o,
  output flash_data_t plain_data_o,
  output code_t       intg_q_o,
  output logic        intg_err_o,
  output logic        fsm_err_o
);

  typedef enum logic [3:0] {
    StIdle,
    StPrePack,
    StPack,
    StPostPack,
    StCalcCode,
    StMask,
    StScramble,
    StReqFlash,
    StWaitFlash,
    StDisabled
  } state_e;

  state_e      state_q, state_d;
  beat_sel_t   idx_q;
  beat_sel_t   sel_m1;
  logic        pack_valid;
  logic        use_beat;
  logic        capture_code;
  logic [BusWidth-1:0] pack_data;
  logic        par_err;
  logic        intg_err_q;
  logic        ack_eff;
  logic        done_eff;
  flash_data_t word_q;
  flash_data_t mask_q;
  code_t       intg_q;

  ////////////////////
  // bus parity
  ////////////////////

  // each byte with its parity bit must hold an odd number of ones
  always_comb begin
    par_err = 1'b0;
    for (int b = 0; b < BusParW; b++) begin
      par_err = par_err |
                ~^{data_i[BusWidth+b], data_i[b*ByteWidth +: ByteWidth]};
    end
  end

  // sticky until reset, only real beats are checked
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intg_err_q <= 1'b0;
    end else if (pack_valid && use_beat && par_err) begin
      intg_err_q <= 1'b1;
    end
  end

  assign intg_err_o = intg_err_q;

  // after a bad beat the flash is never asked, so handshakes are faked
  assign ack_eff  = flash_ack_i | intg_err_q;
  assign done_eff = flash_done_i | intg_err_q;

  ////////////////////
  // beat index
  ////////////////////

  assign sel_m1 = sel_i - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (pack_valid && idx_q == MaxBeatIdx) begin
      // word full, next one starts at slot 0
      idx_q <= '0;
    end else if (pack_valid) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // filler is all ones
  assign pack_data = use_beat ? data_i[BusWidth-1:0] : {BusWidth{1'b1}};

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    pack_valid   = 1'b0;
    use_beat     = 1'b0;
    capture_code = 1'b0;
    prog_ack_o   = 1'b0;
    flash_req_o  = 1'b0;
    flash_last_o = 1'b0;
    mask_req_o   = 1'b0;
    cipher_req_o = 1'b0;
    fsm_err_o    = 1'b0;

    unique case (state_q)
      StIdle: begin
        // disable only takes effect between bursts
        if (disable_i) begin
          state_d = StDisabled;
        end else if (prog_req_i && |sel_i) begin
          state_d = StPrePack;
        end else if (prog_req_i) begin
          state_d = StPack;
        end
      end
      StPrePack: begin
        // filler up to the slot of the first beat
        pack_valid = 1'b1;
        if (idx_q == sel_m1) begin
          state_d = StPack;
        end
      end
      StPack: begin
        pack_valid = prog_req_i;
        use_beat   = 1'b1;
        if (prog_req_i && idx_q == MaxBeatIdx) begin
          // word complete, this beat is acked once the flash takes the word
          state_d = StCalcCode;
        end else if (prog_req_i && last_i) begin
          state_d = StPostPack;
        end else if (prog_req_i) begin
          prog_ack_o = 1'b1;
        end
      end
      StPostPack: begin
        // filler after an unaligned last beat
        pack_valid = 1'b1;
        if (idx_q == MaxBeatIdx) begin
          state_d = StCalcCode;
        end
      end
      StCalcCode: begin
        // integrity code of the plain word
        capture_code = 1'b1;
        state_d = scramble_en_i ? StMask : StReqFlash;
      end
      StMask: begin
        mask_req_o = 1'b1;
        if (mask_ack_i) begin
          state_d = StScramble;
        end
      end
      StScramble: begin
        cipher_req_o = 1'b1;
        if (cipher_ack_i) begin
          state_d = StReqFlash;
        end
      end
      StReqFlash: begin
        flash_req_o  = ~intg_err_q;
        flash_last_o = last_i;
        if (ack_eff && last_i) begin
          // burst ends only when the flash reports done
          state_d = StWaitFlash;
        end else if (ack_eff) begin
          prog_ack_o = 1'b1;
          state_d = StIdle;
        end
      end
      StWaitFlash: begin
        if (done_eff) begin
          prog_ack_o = 1'b1;
          state_d = StIdle;
        end
      end
      StDisabled: begin
        state_d = StDisabled;
      end
      default: begin
        fsm_err_o = 1'b1;
      end
    endcase
  end

  ////////////////////
  // word register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (mask_req_o && mask_ack_i) begin
      // xor in the mask and keep it for the unmask after the cipher
      word_q <= word_q ^ mask_i;
      mask_q <= mask_i;
    end else if (cipher_req_o && cipher_ack_i) begin
      word_q <= cipher_i ^ mask_q;
    end else if (pack_valid) begin
      word_q[idx_q*BusWidth +: BusWidth] <= pack_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_code) begin
      intg_q <= intg_code_i;
    end
  end

  assign cipher_data_o = word_q;
  assign plain_data_o  = word_q;
  assign intg_q_o      = intg_q;

  // reliability field reads as all ones when ecc is off
  assign flash_data_o = {(ecc_en_i ? rel_code_i : {CodeWidth{1'b1}}), intg_q, word_q};

  ////////////////////
  // assertions
  ////////////////////

  // pre-pack fills only slots below the first beat
  pre_pack_slot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == StPrePack && pack_valid |-> idx_q != MaxBeatIdx);

  // post-pack would not be entered on an aligned word
  post_pack_slot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == StPostPack && pack_valid |-> idx_q != '0);

  // the flash request and its word hold until accepted
  flash_req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flash_req_o && !flash_ack_i |=> flash_req_o && $stable(flash_data_o));

endmodule

// ==== hw/flash_prog_top.sv ====
`timescale 1ns/100ps

module flash_prog_top import flash_prog_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        disable_i,
  // controller side
  input  logic        prog_req_i,
  input  bus_word_t   data_i,
  input  beat_sel_t   sel_i,
  input  logic        last_i,
  input  logic        scramble_en_i,
  input  logic        ecc_en_i,
  input  flash_key_t  key_i,
  input  flash_addr_t addr_i,
  output logic        prog_ack_o,
  // flash side
  input  logic        flash_ack_i,
  input  logic        flash_done_i,
  output logic        flash_req_o,
  output logic        flash_last_o,
  output flash_word_t flash_data_o,
  output logic        intg_err_o,
  output logic        fsm_err_o
);

  logic        mask_req;
  logic        mask_ack;
  flash_data_t mask;
  logic        cipher_req;
  logic        cipher_ack;
  flash_data_t cipher_in;
  flash_data_t cipher_out;
  flash_data_t plain_data;
  code_t       intg_q;
  code_t       intg_code;
  code_t       rel_code;

  ////////////////////
  // packer
  ////////////////////

  flash_prog_pack u_pack (
    .clk_i, .rst_ni, .disable_i,
    .prog_req_i, .data_i, .sel_i, .last_i,
    .scramble_en_i, .ecc_en_i,
    .flash_ack_i, .flash_done_i,
    .mask_ack_i    (mask_ack),
    .mask_i        (mask),
    .cipher_ack_i  (cipher_ack),
    .cipher_i      (cipher_out),
    .intg_code_i   (intg_code),
    .rel_code_i    (rel_code),
    .prog_ack_o, .flash_req_o, .flash_last_o, .flash_data_o,
    .mask_req_o    (mask_req),
    .cipher_req_o  (cipher_req),
    .cipher_data_o (cipher_in),
    .plain_data_o  (plain_data),
    .intg_q_o      (intg_q),
    .intg_err_o, .fsm_err_o
  );

  // scrambler and encoder both work off the packer's word register
  flash_prog_scramble u_scramble (
    .clk_i, .rst_ni, .key_i, .addr_i,
    .mask_req_i    (mask_req),
    .mask_ack_o    (mask_ack),
    .mask_o        (mask),
    .cipher_req_i  (cipher_req),
    .cipher_data_i (cipher_in),
    .cipher_ack_o  (cipher_ack),
    .cipher_o      (cipher_out)
  );

  flash_prog_ecc_enc u_ecc_enc (
    .data_i      (plain_data),
    .intg_i      (intg_q),
    .intg_code_o (intg_code),
    .rel_code_o  (rel_code)
  );

endmodule

// ==== verif/flash_prog_tb_model.svh ====
`ifndef FLASH_PROG_TB_MODEL_SVH
`define FLASH_PROG_TB_MODEL_SVH

////////////////////
// bus beats
////////////////////

// one odd-parity bit per byte
function automatic logic [BusParW-1:0] odd_parity(logic [BusWidth-1:0] d);
  logic [BusParW-1:0] p;
  for (int b = 0; b < BusParW; b++) begin
    p[b] = ~^d[b*ByteWidth +: ByteWidth];
  end
  return p;
endfunction

////////////////////
// codes
////////////////////

// walk the set bits of the input and flip the code bits they touch
function automatic code_t rule_code(logic [CodeInWidth-1:0] v, int n);
  code_t c;
  c = '0;
  for (int i = 0; i < n; i++) begin
    if (v[i]) begin
      c[6] = ~c[6];
      if (i % 2 == 0) begin
        c[7] = ~c[7];
      end
      // weights use the index modulo 64
      for (int j = 0; j < 6; j++) begin
        if ((((i % DataWidth) >> j) & 1) == 1) begin
          c[j] = ~c[j];
        end
      end
    end
  end
  return c;
endfunction

////////////////////
// scrambling
////////////////////

function automatic flash_data_t rot_left(flash_data_t x, int r);
  return (x << r) | (x >> (DataWidth - r));
endfunction

// address mask after all rounds
function automatic flash_data_t model_mask(flash_key_t key, flash_addr_t addr);
  flash_data_t m;
  m = key ^ {{(DataWidth - AddrWidth){1'b0}}, addr};
  repeat (MaskRounds) begin
    m = rot_left(m, MaskRot) ^ key;
  end
  return m;
endfunction

// add-rotate rounds, the sum wraps at 64 bits
function automatic flash_data_t model_cipher(flash_data_t d, flash_key_t key);
  flash_data_t c;
  c = d;
  repeat (CipherRounds) begin
    c = rot_left(c + key, CipherRot);
  end
  return c;
endfunction

// full programmed word from the plain packed data
function automatic flash_word_t model_word(flash_data_t plain, logic scr, logic ecc,
                                           flash_key_t key, flash_addr_t addr);
  flash_data_t mask;
  flash_data_t data;
  code_t       intg;
  code_t       rel;
  intg = rule_code({{CodeWidth{1'b0}}, plain}, DataWidth);
  data = plain;
  if (scr) begin
    mask = model_mask(key, addr);
    data = model_cipher(plain ^ mask, key) ^ mask;
  end
  // reliability code covers the integrity code above the final data
  rel = ecc ? rule_code({intg, data}, CodeInWidth) : {CodeWidth{1'b1}};
  return {rel, intg, data};
endfunction

// pack the beats of the burst with all-ones filler and queue the words
task automatic predict_burst(input int start, input logic scr, input logic ecc,
                             input flash_key_t key, input flash_addr_t addr);
  int          nwords;
  int          k;
  flash_data_t plain;
  nwords = (start + beat_q.size() + WidthMultiple - 1) / WidthMultiple;
  for (int w = 0; w < nwords; w++) begin
    for (int s = 0; s < WidthMultiple; s++) begin
      k = w * WidthMultiple + s - start;
      if (k >= 0 && k < beat_q.size()) begin
        plain[s*BusWidth +: BusWidth] = beat_q[k];
      end else begin
        plain[s*BusWidth +: BusWidth] = {BusWidth{1'b1}};
      end
    end
    exp_word_q.push_back(model_word(plain, scr, ecc, key, addr));
    exp_last_q.push_back(w == nwords - 1);
  end
endtask

`endif

// ==== verif/flash_prog_tb.sv ====
`timescale 1ns/100ps

module flash_prog_tb import flash_prog_pkg::*; ();

  localparam int ClkPeriod     = 20;
  localparam int NumBursts     = 12;
  localparam int BurstCycles   = 200;
  // random bursts plus the parity and disable runs
  localparam int WatchdogTime  = (NumBursts + 2) * BurstCycles * ClkPeriod;
  localparam int DisableCycles = 30;

  logic        clk_i;
  logic        rst_ni;
  logic        disable_i;
  logic        prog_req_i;
  bus_word_t   data_i;
  beat_sel_t   sel_i;
  logic        last_i;
  logic        scramble_en_i;
  logic        ecc_en_i;
  flash_key_t  key_i;
  flash_addr_t addr_i;
  logic        prog_ack_o;
  logic        flash_ack_i;
  logic        flash_done_i;
  logic        flash_req_o;
  logic        flash_last_o;
  flash_word_t flash_data_o;
  logic        intg_err_o;
  logic        fsm_err_o;

  // stimulus stream, and a second one so flash delays do not depend on process order
  integer seed       = 32'h20f7_e479;
  integer flash_seed = 32'h20f7_e479 ^ 32'h0000_ffff;

  logic [BusWidth-1:0] beat_q[$];
  flash_word_t         exp_word_q[$];
  logic                exp_last_q[$];
  logic                done_pulsed;
  logic                expect_err;
  logic                err_seen;
  int                  ack_cnt;

  `include "flash_prog_tb_model.svh"

  flash_prog_top u_flash_prog_top (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // reporting
  ////////////////////

  task automatic report_value(input string name, input logic [FullDataWidth-1:0] got,
                              input logic [FullDataWidth-1:0] exp);
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  initial begin : watchdog
    #(WatchdogTime);
    report_error("watchdog timeout, a handshake never completed");
  end

  ////////////////////
  // controller side
  ////////////////////

  // enters and leaves on a falling edge, reset held for 4 cycles
  task automatic apply_reset();
    rst_ni      = 1'b0;
    prog_req_i  = 1'b0;
    disable_i   = 1'b0;
    expect_err  = 1'b0;
    exp_word_q.delete();
    exp_last_q.delete();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // hold one beat until the DUT acks it
  task automatic send_beat(input logic [BusWidth-1:0] d, input int slot,
                           input logic last, input logic bad_par);
    int                 gap;
    logic [BusParW-1:0] par;
    gap = {$random(seed)} % 3;
    repeat (gap) begin
      prog_req_i             = 1'b0;
      data_i[BusWidth-1:0]   = $random(seed);
      @(negedge clk_i);
    end
    par = odd_parity(d);
    if (bad_par) begin
      par[0] = ~par[0];
    end
    prog_req_i = 1'b1;
    data_i     = {par, d};
    sel_i      = beat_sel_t'(slot % WidthMultiple);
    last_i     = last;
    @(posedge clk_i);
    while (!prog_ack_o) @(posedge clk_i);
    // burst may only close once the flash reported done
    if (last && !expect_err) begin
      assert (done_pulsed) else report_error("final prog_ack_o came before flash_done_i");
    end
    @(negedge clk_i);
    prog_req_i = 1'b0;
  endtask

  task automatic run_burst(input int start, input int nbeats, input logic scr,
                           input logic ecc);
    scramble_en_i = scr;
    ecc_en_i      = ecc;
    key_i         = {$random(seed), $random(seed)};
    addr_i        = $random(seed);
    beat_q.delete();
    for (int i = 0; i < nbeats; i++) begin
      beat_q.push_back($random(seed));
    end
    predict_burst(start, scr, ecc, key_i, addr_i);
    done_pulsed = 1'b0;
    ack_cnt     = 0;
    for (int i = 0; i < nbeats; i++) begin
      send_beat(beat_q[i], start + i, i == nbeats - 1, 1'b0);
    end
    assert (exp_word_q.size() == 0)
      else report_error("burst ended before every word reached the flash");
    assert (ack_cnt == nbeats) else report_value("prog_ack_o count", ack_cnt, nbeats);
  endtask

  // first beat carries a flipped parity bit, no word may reach the flash
  task automatic parity_burst();
    int nbeats;
    nbeats = 3 + {$random(seed)} % 4;
    apply_reset();
    expect_err    = 1'b1;
    scramble_en_i = 1'b0;
    ecc_en_i      = 1'b1;
    for (int i = 0; i < nbeats; i++) begin
      send_beat($random(seed), i, i == nbeats - 1, i == 0);
    end
    assert (intg_err_o) else report_error("intg_err_o not set after a beat with bad parity");
  endtask

  // disable taken in idle sticks after the pin drops
  task automatic disable_check();
    logic [BusWidth-1:0] d;
    apply_reset();
    d         = $random(seed);
    disable_i = 1'b1;
    @(negedge clk_i);
    disable_i  = 1'b0;
    prog_req_i = 1'b1;
    data_i     = {odd_parity(d), d};
    sel_i      = '0;
    last_i     = 1'b1;
    repeat (DisableCycles) begin
      @(posedge clk_i);
      assert (!prog_ack_o) else report_error("prog_ack_o pulsed while disabled");
      assert (!flash_req_o) else report_error("flash_req_o raised while disabled");
    end
    @(negedge clk_i);
    prog_req_i = 1'b0;
  endtask

  ////////////////////
  // flash responder
  ////////////////////

  initial begin : flash_responder
    int          delay;
    flash_word_t exp_word;
    logic        exp_last;
    forever begin
      @(negedge clk_i);
      if (flash_req_o) begin
        delay = {$random(flash_seed)} % 4;
        repeat (delay) @(negedge clk_i);
        assert (flash_req_o) else report_error("flash_req_o dropped before accept");
        assert (exp_word_q.size() > 0) else report_error("flash request with no word expected");
        exp_word = exp_word_q.pop_front();
        exp_last = exp_last_q.pop_front();
        assert (flash_data_o === exp_word)
          else report_value("flash_data_o", flash_data_o, exp_word);
        assert (flash_last_o === exp_last)
          else report_value("flash_last_o", flash_last_o, exp_last);
        flash_ack_i = 1'b1;
        @(negedge clk_i);
        flash_ack_i = 1'b0;
        if (exp_last) begin
          delay = {$random(flash_seed)} % 4;
          repeat (delay) @(negedge clk_i);
          done_pulsed  = 1'b1;
          flash_done_i = 1'b1;
          @(negedge clk_i);
          flash_done_i = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // monitor
  ////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      err_seen = 1'b0;
    end else begin
      assert (prog_req_i || !prog_ack_o)
        else report_error("prog_ack_o pulsed with no beat presented");
      assert (!fsm_err_o) else report_error("fsm_err_o raised");
      assert (!(intg_err_o && flash_req_o))
        else report_error("flash_req_o raised after an integrity error");
      if (err_seen) begin
        assert (intg_err_o) else report_error("intg_err_o dropped before reset");
      end
      if (!expect_err) begin
        assert (!intg_err_o) else report_error("intg_err_o raised on good parity");
      end
      err_seen = intg_err_o;
      if (prog_ack_o) begin
        ack_cnt++;
      end
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : stimulus
    rst_ni        = 1'b0;
    disable_i     = 1'b0;
    prog_req_i    = 1'b0;
    data_i        = '0;
    sel_i         = '0;
    last_i        = 1'b0;
    scramble_en_i = 1'b0;
    ecc_en_i      = 1'b0;
    key_i         = '0;
    addr_i        = '0;
    flash_ack_i   = 1'b0;
    flash_done_i  = 1'b0;
    done_pulsed   = 1'b0;
    expect_err    = 1'b0;
    err_seen      = 1'b0;
    ack_cnt       = 0;
    apply_reset();
    // aligned plain burst, ecc off
    run_burst(0, 6, 1'b0, 1'b0);
    // unaligned first and last beat
    run_burst(1, 4, 1'b0, 1'b1);
    // scrambled with ecc, unaligned tail
    run_burst(0, 5, 1'b1, 1'b1);
    for (int b = 3; b < NumBursts; b++) begin
      run_burst({$random(seed)} % WidthMultiple, 1 + {$random(seed)} % 9,
                $random(seed), $random(seed));
    end
    parity_burst();
    disable_check();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verif
hw/flash_prog_pkg.sv
hw/flash_prog_ecc_enc.sv
hw/flash_prog_scramble.sv
hw/flash_prog_pack.sv
hw/flash_prog_top.sv
verif/flash_prog_tb.sv

// ==== Bender.yml ====
package:
  name: flash_prog

sources:
  - hw/flash_prog_pkg.sv
  - hw/flash_prog_ecc_enc.sv
  - hw/flash_prog_scramble.sv
  - hw/flash_prog_pack.sv
  - hw/flash_prog_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/flash_prog_tb.sv
